//--- llr_dec_top.f
+incdir+source
source/llr_dec_pkg.sv
source/qam_llr_mapper.sv
source/llr_frame_buffer.sv
source/hard_dec_output.sv
source/llr_dec_top.sv
testbench/tb_clk_gen.sv
testbench/tb_llr_dec_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f llr_dec_top.f \
  --top-module tb_llr_dec_top \
  -Mdir obj_dir

./obj_dir/Vtb_llr_dec_top | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

//--- source/hard_dec_output.sv
`timescale 1ns/1ps
`include "llr_dec_params.svh"
`default_nettype none

module hard_dec_output import llr_dec_pkg::*; (
  input  logic               iclk,
  input  logic               rst_n,
  input  logic               ireq,
  input  logic               frame_ready,
  input  logic [`LEN_W-1:0]  frame_len,
  input  tag_t               frame_tag,
  input  logic [`ERR_W-1:0]  frame_err,
  input  logic               rd_bit,
  output logic               rd_en,
  output logic [`ADDR_W-1:0] rd_addr,
  output logic               frame_done,
  output logic               ofull,
  output tag_t               otag,
  output logic               osop,
  output logic               oeop,
  output logic               oval,
  output logic               odat,
  output logic [`ERR_W-1:0]  oerr
);

  logic              req_r;
  logic              rd_go;
  logic              last_rd;
  logic [`LEN_W-1:0] rd_cnt;

  // ------------------------------
  // read counter
  // ------------------------------

  // read only when ireq held for two cycles, so no bit follows a low ireq
  assign rd_go   = ireq & req_r & frame_ready;
  assign last_rd = (rd_cnt + 1'b1) == frame_len;

  assign rd_en      = rd_go;
  assign rd_addr    = rd_cnt[`ADDR_W-1:0];
  assign frame_done = rd_go & last_rd;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      req_r  <= 1'b0;
      rd_cnt <= '0;
    end else begin
      req_r <= ireq;
      if (frame_done) begin
        rd_cnt <= '0;
      end else if (rd_go) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // output alignment
  // ------------------------------

  // flags delayed to match the registered memory data
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      oval <= 1'b0;
      osop <= 1'b0;
      oeop <= 1'b0;
    end else begin
      oval <= rd_go;
      osop <= rd_go & (rd_cnt == '0);
      oeop <= frame_done;
    end
  end

  // tag and count kept past the buffer's release
  always_ff @(posedge iclk) begin
    if (rd_go) begin
      otag <= frame_tag;
      oerr <= frame_err;
    end
  end

  assign odat  = rd_bit;
  assign ofull = frame_ready;

endmodule

`default_nettype wire

//--- source/llr_dec_params.svh
`default_nettype none

`ifndef LLR_DEC_PARAMS_SVH
`define LLR_DEC_PARAMS_SVH

// sample and llr width, signed s0.4
`define LLR_W 5

// frame tag width
`define TAG_W 8

// frame store depth in bits, longer frames are cut here
`define N_MAX 64

// |llr| below this value marks the bit as an erasure
`define ERASE_THR 2

// erasure counter width
`define ERR_W 16

// frame store address and frame length widths
`define ADDR_W ($clog2(`N_MAX))
`define LEN_W ($clog2(`N_MAX + 1))

`endif

`default_nettype wire

//--- source/llr_dec_pkg.sv
`include "llr_dec_params.svh"
`default_nettype none

package llr_dec_pkg;

  // ------------------------------
  // modulation of the incoming frame
  // ------------------------------

  // fourth code is unused, the mapper drops such samples
  typedef enum logic [1:0] {
    mod_bpsk = 2'd0,
    mod_qpsk = 2'd1,
    mod_8psk = 2'd2
  } mod_t;

  // ------------------------------
  // data types
  // ------------------------------

  // soft bit, positive means bit 1
  typedef logic signed [`LLR_W-1:0] llr_t;

  // frame tag carried from input to output
  typedef logic [`TAG_W-1:0] tag_t;

  // largest positive llr
  localparam llr_t LLR_MAX = {1'b0, {(`LLR_W-1){1'b1}}};

  // absolute value, most negative input clips to LLR_MAX
  function automatic llr_t abs_sat(input llr_t x);
    llr_t neg;
    neg = -x;
    if (!x[`LLR_W-1]) return x;
    // negating the most negative code wraps back to negative
    if (neg[`LLR_W-1]) return LLR_MAX;
    return neg;
  endfunction

endpackage

`default_nettype wire

//--- source/llr_dec_top.sv
`timescale 1ns/1ps
`include "llr_dec_params.svh"
`default_nettype none

module llr_dec_top import llr_dec_pkg::*; (
  input  logic              iclk,
  input  logic              rst_n,
  input  mod_t              qam,
  input  tag_t              tag,
  input  logic              sop,
  input  logic              eop,
  input  logic              val,
  input  llr_t              dat_re,
  input  llr_t              dat_im,
  input  logic              ireq,
  output logic              ordy,
  output logic              obusy,
  output logic              ofull,
  output tag_t              otag,
  output logic              osop,
  output logic              oeop,
  output logic              oval,
  output logic              odat,
  output logic [`ERR_W-1:0] oerr
);

  // ------------------------------
  // mapper to buffer
  // ------------------------------

  logic llr_val;
  logic llr_sop;
  logic llr_eop;
  llr_t llr;
  tag_t llr_tag;

  // ------------------------------
  // buffer to output stage
  // ------------------------------

  logic               rd_en;
  logic [`ADDR_W-1:0] rd_addr;
  logic               rd_bit;
  logic               frame_ready;
  logic               frame_done;
  logic [`LEN_W-1:0]  frame_len;
  tag_t               frame_tag;
  logic [`ERR_W-1:0]  frame_err;

  qam_llr_mapper u_mapper (
    .iclk    (iclk),
    .rst_n   (rst_n),
    .qam     (qam),
    .tag     (tag),
    .sop     (sop),
    .eop     (eop),
    .val     (val),
    .dat_re  (dat_re),
    .dat_im  (dat_im),
    .llr_val (llr_val),
    .llr_sop (llr_sop),
    .llr_eop (llr_eop),
    .llr     (llr),
    .llr_tag (llr_tag)
  );

  // hard decisions and erasure count, one frame deep
  llr_frame_buffer u_buffer (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .llr_val     (llr_val),
    .llr_sop     (llr_sop),
    .llr_eop     (llr_eop),
    .llr         (llr),
    .llr_tag     (llr_tag),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .frame_done  (frame_done),
    .rd_bit      (rd_bit),
    .frame_ready (frame_ready),
    .frame_len   (frame_len),
    .frame_tag   (frame_tag),
    .frame_err   (frame_err),
    .ordy        (ordy),
    .obusy       (obusy)
  );

  hard_dec_output u_output (
    .iclk        (iclk),
    .rst_n       (rst_n),
    .ireq        (ireq),
    .frame_ready (frame_ready),
    .frame_len   (frame_len),
    .frame_tag   (frame_tag),
    .frame_err   (frame_err),
    .rd_bit      (rd_bit),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .frame_done  (frame_done),
    .ofull       (ofull),
    .otag        (otag),
    .osop        (osop),
    .oeop        (oeop),
    .oval        (oval),
    .odat        (odat),
    .oerr        (oerr)
  );

endmodule

`default_nettype wire

//--- source/llr_frame_buffer.sv
`timescale 1ns/1ps
`include "llr_dec_params.svh"
`default_nettype none

module llr_frame_buffer import llr_dec_pkg::*; (
  input  logic               iclk,
  input  logic               rst_n,
  input  logic               llr_val,
  input  logic               llr_sop,
  input  logic               llr_eop,
  input  llr_t               llr,
  input  tag_t               llr_tag,
  input  logic               rd_en,
  input  logic [`ADDR_W-1:0] rd_addr,
  input  logic               frame_done,
  output logic               rd_bit,
  output logic               frame_ready,
  output logic [`LEN_W-1:0]  frame_len,
  output tag_t               frame_tag,
  output logic [`ERR_W-1:0]  frame_err,
  output logic               ordy,
  output logic               obusy
);

  // write control, a held frame blocks new ones
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_fill = 2'd1,
    st_held = 2'd2
  } wr_state_t;

  wr_state_t state;

  // single-frame bit store
  logic mem [`N_MAX];

  logic [`LEN_W-1:0]  wr_cnt;
  logic [`ERR_W-1:0]  err_cnt;
  tag_t               tag_r;
  logic [`ADDR_W-1:0] wr_addr;
  logic               hard_bit;
  logic               erase;
  logic               start;
  logic               room;
  logic               wr_en;

  // ------------------------------
  // slicer and erasure flag
  // ------------------------------

  // zero slices to 1
  assign hard_bit = !llr[`LLR_W-1];
  assign erase    = abs_sat(llr) < `ERASE_THR;

  // ------------------------------
  // write side
  // ------------------------------

  // a new frame opens only from idle
  assign start = llr_val & llr_sop & (state == st_idle);
  // bits past N_MAX are dropped, eop still closes the frame
  assign room  = wr_cnt < `N_MAX;
  assign wr_en = start | (llr_val & (state == st_fill) & room);

  assign wr_addr = start ? '0 : wr_cnt[`ADDR_W-1:0];

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          // one-bit frame goes straight to held
          if (start) state <= llr_eop ? st_held : st_fill;
        end
        st_fill: begin
          if (llr_val && llr_eop) state <= st_held;
        end
        st_held: begin
          // released once the last bit has been read
          if (frame_done) state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // length and erasure count, frozen while held
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt  <= '0;
      err_cnt <= '0;
    end else if (start) begin
      wr_cnt  <= {{(`LEN_W-1){1'b0}}, 1'b1};
      err_cnt <= {{(`ERR_W-1){1'b0}}, erase};
    end else if (wr_en) begin
      wr_cnt  <= wr_cnt + 1'b1;
      err_cnt <= err_cnt + {{(`ERR_W-1){1'b0}}, erase};
    end
  end

  always_ff @(posedge iclk) begin
    if (start) tag_r <= llr_tag;
    if (wr_en) mem[wr_addr] <= hard_bit;
  end

  // ------------------------------
  // read side
  // ------------------------------

  // registered read, data one cycle after rd_en
  always_ff @(posedge iclk) begin
    if (rd_en) rd_bit <= mem[rd_addr];
  end

  assign frame_ready = (state == st_held);
  assign frame_len   = wr_cnt;
  assign frame_tag   = tag_r;
  assign frame_err   = err_cnt;

  // input side handshake
  assign ordy  = (state == st_idle);
  assign obusy = !ordy;

endmodule

`default_nettype wire

//--- source/qam_llr_mapper.sv
`timescale 1ns/1ps
`include "llr_dec_params.svh"
`default_nettype none

module qam_llr_mapper import llr_dec_pkg::*; (
  input  logic iclk,
  input  logic rst_n,
  input  mod_t qam,
  input  tag_t tag,
  input  logic sop,
  input  logic eop,
  input  logic val,
  input  llr_t dat_re,
  input  llr_t dat_im,
  output logic llr_val,
  output logic llr_sop,
  output logic llr_eop,
  output llr_t llr,
  output tag_t llr_tag
);

  // ------------------------------
  // llr metrics per mode
  // ------------------------------

  // one extra bit so re + im cannot overflow
  logic signed [`LLR_W:0] bpsk_sum;
  llr_t                   bpsk_llr;
  llr_t                   psk8_llr;

  // load values and shift masks for the current sample
  llr_t       ld [3];
  logic [2:0] val_mask;
  logic [2:0] eop_mask;

  // three-entry shift register, entry 2 is the head
  llr_t       sr [3];
  logic [2:0] val_sr;
  logic [2:0] eop_sr;
  logic       sop_r;
  tag_t       tag_r;

  assign bpsk_sum = dat_re + dat_im;
  // arithmetic shift right by one, keeps the sign
  assign bpsk_llr = bpsk_sum[`LLR_W:1];

  // difference of two values in 0..LLR_MAX always fits
  assign psk8_llr = abs_sat(dat_re) - abs_sat(dat_im);

  always_comb begin
    ld[2]    = '0;
    ld[1]    = '0;
    ld[0]    = '0;
    val_mask = 3'b000;
    eop_mask = 3'b000;
    case (qam)
      mod_bpsk: begin
        // one llr per symbol
        ld[2]    = bpsk_llr;
        val_mask = 3'b100;
        eop_mask = 3'b100;
      end
      mod_qpsk: begin
        // re first, then im
        ld[2]    = dat_re;
        ld[1]    = dat_im;
        val_mask = 3'b110;
        eop_mask = 3'b010;
      end
      mod_8psk: begin
        // im, re, then |re| - |im|
        ld[2]    = dat_im;
        ld[1]    = dat_re;
        ld[0]    = psk8_llr;
        val_mask = 3'b111;
        eop_mask = 3'b001;
      end
      default: begin
        // unused mode code, nothing is loaded
        val_mask = 3'b000;
      end
    endcase
  end

  // ------------------------------
  // serializer
  // ------------------------------

  // control shifts toward the head each idle cycle
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      val_sr <= 3'b000;
      eop_sr <= 3'b000;
      sop_r  <= 1'b0;
    end else if (val) begin
      val_sr <= val_mask;
      eop_sr <= eop ? eop_mask : 3'b000;
      sop_r  <= sop;
    end else begin
      val_sr <= val_sr << 1;
      eop_sr <= eop_sr << 1;
      sop_r  <= 1'b0;
    end
  end

  // data path follows the same load and shift
  always_ff @(posedge iclk) begin
    if (val) begin
      sr[2] <= ld[2];
      sr[1] <= ld[1];
      sr[0] <= ld[0];
      tag_r <= tag;
    end else begin
      sr[2] <= sr[1];
      sr[1] <= sr[0];
      sr[0] <= '0;
    end
  end

  assign llr_val = val_sr[2];
  // sop only ever sits with the first llr of a symbol
  assign llr_sop = sop_r & val_sr[2];
  assign llr_eop = eop_sr[2];
  assign llr     = sr[2];
  assign llr_tag = tag_r;

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 10
) (
  output logic iclk,
  output logic rst_n
);

  // free-running clock, starts low
  initial begin
    iclk = 1'b0;
    forever #(PERIOD_NS / 2) iclk = ~iclk;
  end

  // reset held low for RST_CYCLES rising edges
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge iclk);
    // release on a falling edge, away from the sampling edge
    @(negedge iclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_llr_dec_top.sv
`timescale 1ns/1ps
`include "llr_dec_params.svh"
`default_nettype none

module tb_llr_dec_top import llr_dec_pkg::*; ();

  // ------------------------------
  // test sizes and run limit
  // ------------------------------

  localparam int BPSK_SYMS = 24;
  localparam int QPSK_SYMS = 16;
  localparam int PSK8_SYMS = 20;
  // qpsk frame read with a toggling ireq
  localparam int BP_SYMS   = 20;
  // 8psk frame held before read-out, then a bpsk frame
  localparam int HELD_SYMS = 12;
  localparam int NEXT_SYMS = 16;

  localparam int TOTAL_BITS = BPSK_SYMS + 2 * QPSK_SYMS + 3 * PSK8_SYMS +
                              2 * BP_SYMS + 3 * HELD_SYMS + NEXT_SYMS;
  // input, read-out and back-pressure stalls per bit, plus reset and idle time
  localparam int CYCLE_LIMIT = 10 * TOTAL_BITS + 1000;

  // largest llr magnitude
  localparam int LLR_TOP = (1 << (`LLR_W - 1)) - 1;

  // corner samples that open the 8psk frames
  localparam int CORNER_RE [8] = '{-16, -16, 0, 15, 1, 0, -1, -2};
  localparam int CORNER_IM [8] = '{-16, 0, -16, -16, -1, 0, 1, 15};

  // ------------------------------
  // clock, reset and DUT ports
  // ------------------------------

  logic              iclk;
  logic              rst_n;
  mod_t              qam;
  tag_t              tag;
  logic              sop;
  logic              eop;
  logic              val;
  llr_t              dat_re;
  llr_t              dat_im;
  logic              ireq;
  logic              ordy;
  logic              obusy;
  logic              ofull;
  tag_t              otag;
  logic              osop;
  logic              oeop;
  logic              oval;
  logic              odat;
  logic [`ERR_W-1:0] oerr;

  // expected frame, built from the llr, slicer and erasure rules
  bit     exp_bits[$];
  int     exp_err;
  int     errors;
  int     bits_checked;
  int     frames_checked;
  int     cycle_cnt;
  integer seed = 32'h9111;

  tb_clk_gen #(
    .PERIOD_NS  (100),
    .RST_CYCLES (10)
  ) u_clk_gen (
    .iclk  (iclk),
    .rst_n (rst_n)
  );

  llr_dec_top u_llr_dec_top (
    .iclk   (iclk),
    .rst_n  (rst_n),
    .qam    (qam),
    .tag    (tag),
    .sop    (sop),
    .eop    (eop),
    .val    (val),
    .dat_re (dat_re),
    .dat_im (dat_im),
    .ireq   (ireq),
    .ordy   (ordy),
    .obusy  (obusy),
    .ofull  (ofull),
    .otag   (otag),
    .osop   (osop),
    .oeop   (oeop),
    .oval   (oval),
    .odat   (odat),
    .oerr   (oerr)
  );

  // ------------------------------
  // error reporting
  // ------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors = errors + 1;
    $display("[FAIL] %s: got %h, expected %h (t=%0t)", name, got, exp, $time);
  endtask

  task automatic report_problem(input string msg);
    errors = errors + 1;
    $display("error: %s (t=%0t)", msg, $time);
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  // magnitude clipped to the largest positive llr
  function automatic int mag_clipped(input int x);
    int a;
    a = (x < 0) ? -x : x;
    if (a > LLR_TOP) a = LLR_TOP;
    return a;
  endfunction

  // slice one llr and count it when it is weak
  task automatic expect_llr(input int l);
    exp_bits.push_back(l >= 0);
    if (mag_clipped(l) < `ERASE_THR) exp_err = exp_err + 1;
  endtask

  task automatic expect_symbol(input mod_t m, input int re, input int im);
    case (m)
      mod_bpsk: begin
        // floor of the half sum
        expect_llr((re + im) >>> 1);
      end
      mod_qpsk: begin
        expect_llr(re);
        expect_llr(im);
      end
      default: begin
        expect_llr(im);
        expect_llr(re);
        expect_llr(mag_clipped(re) - mag_clipped(im));
      end
    endcase
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  // style 0 is plain random, style 1 starts with corners and mixes in near-zero values
  task automatic pick_sample(input int style, input int i, output int re, output int im);
    logic [31:0] r;
    r  = $random(seed);
    re = $signed(r[`LLR_W-1:0]);
    im = $signed(r[`LLR_W+7:8]);
    if (style == 1 && i < 8) begin
      re = CORNER_RE[i];
      im = CORNER_IM[i];
    end else if (style == 1 && (i % 2) == 0) begin
      // values in -2..1 land on the erasure threshold
      re = int'(r[17:16]) - 2;
      im = int'(r[19:18]) - 2;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_frame(input mod_t m, input tag_t t, input int nsym, input int style);
    int re;
    int im;
    int nbits;
    int i;
    int k;
    nbits = (m == mod_bpsk) ? 1 : ((m == mod_qpsk) ? 2 : 3);
    exp_bits.delete();
    exp_err = 0;
    // a frame may only start while the input side is free
    while (!ordy) @(negedge iclk);
    for (i = 0; i < nsym; i++) begin
      pick_sample(style, i, re, im);
      expect_symbol(m, re, im);
      qam    = m;
      tag    = t;
      sop    = (i == 0);
      eop    = (i == nsym - 1);
      val    = 1'b1;
      dat_re = re[`LLR_W-1:0];
      dat_im = im[`LLR_W-1:0];
      @(negedge iclk);
      val = 1'b0;
      sop = 1'b0;
      eop = 1'b0;
      // idle gap so the mapper can shift out the remaining llrs
      for (k = 1; k < nbits; k++) @(negedge iclk);
    end
    // idle input tag differs from the one stored with the frame
    tag = ~t;
  endtask

  // ------------------------------
  // read-out and compare
  // ------------------------------

  task automatic read_frame(input tag_t t, input bit toggle);
    int          idx;
    int          n;
    bit          done;
    logic        ireq_prev;
    logic [31:0] r;
    n         = exp_bits.size();
    idx       = 0;
    done      = 0;
    ireq_prev = 1'b0;
    while (!ofull) @(negedge iclk);
    ireq = 1'b1;
    while (!done) begin
      @(negedge iclk);
      // a bit needs ireq on this cycle and the one before
      if (oval && !(ireq && ireq_prev)) begin
        report_problem("oval came out although ireq was low the cycle before");
      end
      // and with ireq high on both cycles the next bit is due
      if (!oval && ireq && ireq_prev) begin
        report_problem("no bit came out although ireq was high for two cycles");
      end
      if (oval) begin
        if (idx >= n) begin
          report_problem("the DUT sent more bits than the frame holds");
          done = 1;
        end else begin
          if (odat !== exp_bits[idx]) report_mismatch("odat", odat, exp_bits[idx]);
          if (osop !== (idx == 0)) report_mismatch("osop", osop, (idx == 0));
          if (oeop !== (idx == n - 1)) report_mismatch("oeop", oeop, (idx == n - 1));
          if (otag !== t) report_mismatch("otag", otag, t);
          if (oerr !== exp_err) report_mismatch("oerr", oerr, exp_err);
          bits_checked = bits_checked + 1;
          idx          = idx + 1;
          if (oeop) done = 1;
        end
      end else if (osop || oeop) begin
        report_problem("osop or oeop is high without oval");
      end
      // frame stays held until the last bit is out
      if (!done) begin
        if (ofull !== 1'b1) report_mismatch("ofull", ofull, 1'b1);
        if (ordy !== 1'b0) report_mismatch("ordy", ordy, 1'b0);
      end
      ireq_prev = ireq;
      if (toggle) begin
        r    = $random(seed);
        ireq = r[0];
      end
    end
    ireq = 1'b0;
    if (idx != n) report_problem($sformatf("frame ended after %0d of %0d bits", idx, n));
    if (ofull !== 1'b0) report_mismatch("ofull", ofull, 1'b0);
    if (ordy !== 1'b1) report_mismatch("ordy", ordy, 1'b1);
    frames_checked = frames_checked + 1;
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic check_reset_state();
    if (ordy !== 1'b1) report_mismatch("ordy", ordy, 1'b1);
    if (obusy !== 1'b0) report_mismatch("obusy", obusy, 1'b0);
    if (ofull !== 1'b0) report_mismatch("ofull", ofull, 1'b0);
    if (oval !== 1'b0) report_mismatch("oval", oval, 1'b0);
    if (osop !== 1'b0) report_mismatch("osop", osop, 1'b0);
    if (oeop !== 1'b0) report_mismatch("oeop", oeop, 1'b0);
  endtask

  task automatic test_bpsk_frame();
    send_frame(mod_bpsk, 8'ha5, BPSK_SYMS, 0);
    read_frame(8'ha5, 1'b0);
  endtask

  task automatic test_qpsk_frame();
    send_frame(mod_qpsk, 8'h3c, QPSK_SYMS, 0);
    read_frame(8'h3c, 1'b0);
  endtask

  task automatic test_8psk_corners();
    send_frame(mod_8psk, 8'h81, PSK8_SYMS, 1);
    read_frame(8'h81, 1'b0);
  endtask

  task automatic test_backpressure();
    send_frame(mod_qpsk, 8'h5a, BP_SYMS, 0);
    read_frame(8'h5a, 1'b1);
  endtask

  task automatic test_held_frame();
    int k;
    send_frame(mod_8psk, 8'h6c, HELD_SYMS, 1);
    while (!ofull) @(negedge iclk);
    // sink silent, frame must stay put
    for (k = 0; k < 20; k++) begin
      @(negedge iclk);
      if (ordy !== 1'b0) report_mismatch("ordy", ordy, 1'b0);
      if (obusy !== 1'b1) report_mismatch("obusy", obusy, 1'b1);
      if (ofull !== 1'b1) report_mismatch("ofull", ofull, 1'b1);
      if (oval !== 1'b0) report_mismatch("oval", oval, 1'b0);
    end
    read_frame(8'h6c, 1'b0);
    // next frame goes in once the store is free again
    send_frame(mod_bpsk, 8'hd2, NEXT_SYMS, 0);
    read_frame(8'hd2, 1'b0);
  endtask

  // ------------------------------
  // main sequence and timeout
  // ------------------------------

  initial begin : main
    qam            = mod_bpsk;
    tag            = '0;
    sop            = 1'b0;
    eop            = 1'b0;
    val            = 1'b0;
    dat_re         = '0;
    dat_im         = '0;
    ireq           = 1'b0;
    errors         = 0;
    bits_checked   = 0;
    frames_checked = 0;
    exp_err        = 0;
    // reset is released on a falling edge
    @(posedge rst_n);
    check_reset_state();
    test_bpsk_frame();
    test_qpsk_frame();
    test_8psk_corners();
    test_backpressure();
    test_held_frame();
    $display("frames %0d, bits %0d, errors %0d", frames_checked, bits_checked, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge iclk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("error: timeout after %0d cycles, a frame never completed", cycle_cnt);
    $display("frames %0d, bits %0d, errors %0d", frames_checked, bits_checked, errors);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
